/* hdl/mem_geom_pkg.sv */
// fixed geometry of 16 banks of 32-byte lines over a 19-bit byte address, no other sizes
package mem_geom_pkg;

	// ----------------------------------------
	// address geometry
	// ----------------------------------------

	// byte address seen by the clients
	localparam int ADDR_W = 19;

	// one bank line holds this many bytes
	localparam int LINE_BYTES = 32;

	// byte offset inside a line, address bits 4..0
	localparam int OFFSET_W = 5;

	// bank index is {addr[18:16], addr[5]}
	localparam int NUM_BANKS = 16;

	// row inside a bank, address bits 15..6
	localparam int ROW_W = 10;

	// ----------------------------------------
	// types
	// ----------------------------------------

	typedef logic [ADDR_W-1:0] addr_t;

	typedef logic [$clog2(NUM_BANKS)-1:0] bank_t;

	typedef logic [ROW_W-1:0] row_t;

	typedef logic [OFFSET_W-1:0] offset_t;

	// byte 0 of the line sits in bits 7..0
	typedef logic [LINE_BYTES*8-1:0] line_t;

	// one enable per byte of a line
	typedef logic [LINE_BYTES-1:0] bmask_t;

endpackage

/* hdl/mem_ctrl_pkg.sv */
// request length is limited to 1..32 bytes, a size of 0 is not supported
package mem_ctrl_pkg;

	// ----------------------------------------
	// client side
	// ----------------------------------------

	localparam int NUM_CLIENTS = 4;

	// request length in bytes, 1 to 32
	typedef logic [5:0] size_t;

	// read wins when a client raises both request lines
	typedef enum logic {
		READ_OP,
		WRITE_OP
	} op_e;

	// ONE / TWO is the number of lines the address spans
	typedef enum logic [2:0] {
		IDLE,
		READ_ONE,
		READ_TWO,
		WRITE_ONE,
		WRITE_TWO
	} seq_state_e;

endpackage

/* hdl/line_split.sv */
// combinational only; size must be 1..32, so a request never spans more than two lines
`timescale 1ns/1ps

module line_split (
	input  mem_ctrl_pkg::op_e   op,
	input  mem_geom_pkg::addr_t start_addr,
	input  mem_ctrl_pkg::size_t size,
	input  mem_geom_pkg::line_t wr_data,
	output logic                two_line,
	output mem_geom_pkg::bank_t bank0,
	output mem_geom_pkg::bank_t bank1,
	output mem_geom_pkg::row_t  row0,
	output mem_geom_pkg::row_t  row1,
	output mem_geom_pkg::line_t wdata0,
	output mem_geom_pkg::line_t wdata1,
	output mem_geom_pkg::bmask_t bmask0,
	output mem_geom_pkg::bmask_t bmask1
);
	import mem_geom_pkg::*;
	import mem_ctrl_pkg::*;

	// start of the following line, same mapping as the first
	addr_t   next_addr;
	offset_t offset;
	// end of the request measured from the line start, up to 63
	logic [6:0] span_end;
	// bytes that land in line 0 and in line 1
	size_t first_bytes;
	size_t second_bytes;
	// low-aligned runs of ones, one extra bit so a full line fits
	logic [LINE_BYTES:0] ones0;
	logic [LINE_BYTES:0] ones1;

	// ----------------------------------------
	// bank and row mapping
	// ----------------------------------------

	assign offset    = start_addr[OFFSET_W-1:0];
	assign next_addr = start_addr + addr_t'(LINE_BYTES);

	// region from bits 18..16, odd/even bank from bit 5
	assign bank0 = {start_addr[18:16], start_addr[5]};
	assign bank1 = {next_addr[18:16], next_addr[5]};
	assign row0  = start_addr[15:6];
	assign row1  = next_addr[15:6];

	// ----------------------------------------
	// byte counts per line
	// ----------------------------------------

	assign span_end = {2'b00, offset} + {1'b0, size};
	assign two_line = span_end > 7'(LINE_BYTES);

	// line 0 takes the bytes up to its end, the rest spill to line 1
	assign first_bytes  = two_line ? size_t'(LINE_BYTES) - size_t'(offset) : size;
	assign second_bytes = size - first_bytes;

	// ----------------------------------------
	// data placement and byte enables
	// ----------------------------------------

	// move byte 0 of the client data up to the start offset
	assign wdata0 = wr_data << {offset, 3'b000};
	// bytes already placed in line 0 are dropped for line 1
	assign wdata1 = wr_data >> {first_bytes, 3'b000};

	assign ones0 = ({{LINE_BYTES{1'b0}}, 1'b1} << first_bytes) - 1'b1;
	assign ones1 = ({{LINE_BYTES{1'b0}}, 1'b1} << second_bytes) - 1'b1;

	// reads write nothing, so their masks stay clear
	assign bmask0 = (op == WRITE_OP) ? (ones0[LINE_BYTES-1:0] << offset) : '0;
	// line 1 always starts at byte 0
	assign bmask1 = (op == WRITE_OP && two_line) ? ones1[LINE_BYTES-1:0] : '0;

endmodule

/* hdl/access_seq.sv */
// one request in flight per client; request fields must stay stable until rd_valid or wr_ack
`timescale 1ns/1ps

module access_seq (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                rd_req,
	input  logic                                wr_req,
	input  mem_geom_pkg::addr_t                 start_addr,
	input  mem_ctrl_pkg::size_t                 size,
	input  mem_geom_pkg::line_t                 wr_data,
	input  logic [mem_geom_pkg::NUM_BANKS-1:0]  gnt_col,
	output mem_ctrl_pkg::op_e                   cur_op,
	output logic                                cur_two,
	output mem_geom_pkg::bank_t                 cur_bank0,
	output mem_geom_pkg::bank_t                 cur_bank1,
	output mem_geom_pkg::row_t                  cur_row0,
	output mem_geom_pkg::row_t                  cur_row1,
	output mem_geom_pkg::line_t                 cur_wdata0,
	output mem_geom_pkg::line_t                 cur_wdata1,
	output mem_geom_pkg::bmask_t                cur_bmask0,
	output mem_geom_pkg::bmask_t                cur_bmask1,
	output mem_geom_pkg::offset_t               cur_offset,
	output logic [mem_geom_pkg::NUM_BANKS-1:0]  bank_req_row,
	output logic                                line0_got,
	output logic                                line1_got,
	output logic                                rd_valid,
	output logic                                wr_ack
);
	import mem_geom_pkg::*;
	import mem_ctrl_pkg::*;

	seq_state_e state;
	seq_state_e next_state;
	op_e        req_op;
	// split of the live request, sampled in IDLE
	logic   sp_two;
	bank_t  sp_bank0;
	bank_t  sp_bank1;
	row_t   sp_row0;
	row_t   sp_row1;
	line_t  sp_wdata0;
	line_t  sp_wdata1;
	bmask_t sp_bmask0;
	bmask_t sp_bmask1;
	logic   capture;
	// open bank request per line, and line granted
	logic   req0;
	logic   req1;
	logic   done0;
	logic   done1;
	logic   g0;
	logic   g1;
	logic   fire;

	// read wins over write
	assign req_op = rd_req ? READ_OP : WRITE_OP;

	line_split line_split_i (
		.op         (req_op),
		.start_addr (start_addr),
		.size       (size),
		.wr_data    (wr_data),
		.two_line   (sp_two),
		.bank0      (sp_bank0),
		.bank1      (sp_bank1),
		.row0       (sp_row0),
		.row1       (sp_row1),
		.wdata0     (sp_wdata0),
		.wdata1     (sp_wdata1),
		.bmask0     (sp_bmask0),
		.bmask1     (sp_bmask1)
	);

	// ----------------------------------------
	// sequencer
	// ----------------------------------------

	assign capture = (state == IDLE) && (rd_req || wr_req);

	// valid lands with the last line's data, ack one cycle after the last grant
	assign rd_valid = (state == READ_ONE && done0) || (state == READ_TWO && done0 && done1);
	assign wr_ack   = (state == WRITE_ONE && done0) || (state == WRITE_TWO && done0 && done1);
	assign fire     = rd_valid || wr_ack;

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (rd_req) begin
					next_state = sp_two ? READ_TWO : READ_ONE;
				end else if (wr_req) begin
					next_state = sp_two ? WRITE_TWO : WRITE_ONE;
				end
			end
			READ_ONE, READ_TWO, WRITE_ONE, WRITE_TWO: begin
				if (fire) begin
					next_state = IDLE;
				end
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	// captured request, held for the bank muxes and the read merge
	always_ff @(posedge clk) begin
		if (capture) begin
			cur_op     <= req_op;
			cur_two    <= sp_two;
			cur_bank0  <= sp_bank0;
			cur_bank1  <= sp_bank1;
			cur_row0   <= sp_row0;
			cur_row1   <= sp_row1;
			cur_wdata0 <= sp_wdata0;
			cur_wdata1 <= sp_wdata1;
			cur_bmask0 <= sp_bmask0;
			cur_bmask1 <= sp_bmask1;
			cur_offset <= start_addr[OFFSET_W-1:0];
		end
	end

	// ----------------------------------------
	// bank requests and grant tracking
	// ----------------------------------------

	// the two banks of a split request always differ in bit 5
	assign g0 = req0 && gnt_col[cur_bank0];
	assign g1 = req1 && gnt_col[cur_bank1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req0      <= 1'b0;
			req1      <= 1'b0;
			done0     <= 1'b0;
			done1     <= 1'b0;
			line0_got <= 1'b0;
			line1_got <= 1'b0;
		end else begin
			// strobes mark the cycle the granted line is on bank_rdata
			line0_got <= g0;
			line1_got <= g1;
			if (capture) begin
				req0  <= 1'b1;
				req1  <= sp_two;
				done0 <= 1'b0;
				done1 <= 1'b0;
			end else begin
				// either order, or both in one cycle
				if (g0) begin
					req0  <= 1'b0;
					done0 <= 1'b1;
				end
				if (g1) begin
					req1  <= 1'b0;
					done1 <= 1'b1;
				end
			end
		end
	end

	always_comb begin
		bank_req_row = '0;
		if (req0) begin
			bank_req_row[cur_bank0] = 1'b1;
		end
		if (req1) begin
			bank_req_row[cur_bank1] = 1'b1;
		end
	end

endmodule

/* hdl/read_merge.sv */
// bytes of rd_data past the requested size are don't-care
`timescale 1ns/1ps

module read_merge (
	input  logic                                               clk,
	input  logic                                               rst_n,
	input  mem_geom_pkg::line_t [mem_geom_pkg::NUM_BANKS-1:0]  bank_rdata,
	input  mem_geom_pkg::bank_t                                cur_bank0,
	input  mem_geom_pkg::bank_t                                cur_bank1,
	input  logic                                               cur_two,
	input  mem_geom_pkg::offset_t                              cur_offset,
	input  logic                                               line0_got,
	input  logic                                               line1_got,
	output mem_geom_pkg::line_t                                rd_data
);
	import mem_geom_pkg::*;

	// lines that came back before the last one
	line_t line0_q;
	line_t line1_q;
	// current view of each line
	line_t line0;
	line_t line1;
	line_t upper;
	logic [2*LINE_BYTES*8-1:0] joined;

	// ----------------------------------------
	// line capture
	// ----------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			line0_q <= '0;
			line1_q <= '0;
		end else begin
			if (line0_got) begin
				line0_q <= bank_rdata[cur_bank0];
			end
			if (line1_got) begin
				line1_q <= bank_rdata[cur_bank1];
			end
		end
	end

	// bypass the register for a line arriving in this very cycle
	assign line0 = line0_got ? bank_rdata[cur_bank0] : line0_q;
	assign line1 = line1_got ? bank_rdata[cur_bank1] : line1_q;

	// ----------------------------------------
	// alignment
	// ----------------------------------------

	// single-line reads pull zeros in from above
	assign upper = cur_two ? line1 : '0;

	// line 1 continues line 0, then drop the leading offset bytes
	assign joined  = {upper, line0} >> {cur_offset, 3'b000};
	assign rd_data = joined[LINE_BYTES*8-1:0];

endmodule

/* hdl/bank_port_mux.sv */
// gnt_row must be at most one-hot; with no grant only bank_cs and bank_we are meaningful
`timescale 1ns/1ps

module bank_port_mux #(
	parameter int bank_idx = 0
) (
	input  logic [mem_ctrl_pkg::NUM_CLIENTS-1:0]                       gnt_row,
	input  mem_ctrl_pkg::op_e    [mem_ctrl_pkg::NUM_CLIENTS-1:0]       cur_op,
	input  mem_geom_pkg::bank_t  [mem_ctrl_pkg::NUM_CLIENTS-1:0]       cur_bank0,
	input  mem_geom_pkg::row_t   [mem_ctrl_pkg::NUM_CLIENTS-1:0]       cur_row0,
	input  mem_geom_pkg::row_t   [mem_ctrl_pkg::NUM_CLIENTS-1:0]       cur_row1,
	input  mem_geom_pkg::line_t  [mem_ctrl_pkg::NUM_CLIENTS-1:0]       cur_wdata0,
	input  mem_geom_pkg::line_t  [mem_ctrl_pkg::NUM_CLIENTS-1:0]       cur_wdata1,
	input  mem_geom_pkg::bmask_t [mem_ctrl_pkg::NUM_CLIENTS-1:0]       cur_bmask0,
	input  mem_geom_pkg::bmask_t [mem_ctrl_pkg::NUM_CLIENTS-1:0]       cur_bmask1,
	output logic                                                       bank_cs,
	output logic                                                       bank_we,
	output mem_geom_pkg::row_t                                         bank_row,
	output mem_geom_pkg::line_t                                        bank_wdata,
	output mem_geom_pkg::bmask_t                                       bank_bmask
);
	import mem_geom_pkg::*;
	import mem_ctrl_pkg::*;

	// index of the granted client
	logic [$clog2(NUM_CLIENTS)-1:0] sel;
	// this bank holds the granted client's first line
	logic first_line;

	// ----------------------------------------
	// granted client
	// ----------------------------------------

	always_comb begin
		sel = '0;
		for (int c = 0; c < NUM_CLIENTS; c++) begin
			if (gnt_row[c]) begin
				sel = $bits(sel)'(c);
			end
		end
	end

	// the select is active in the grant cycle itself
	assign bank_cs = |gnt_row;

	// ----------------------------------------
	// port fields
	// ----------------------------------------

	// a split request never maps both lines to one bank
	assign first_line = (cur_bank0[sel] == bank_t'(bank_idx));

	assign bank_we    = bank_cs && (cur_op[sel] == WRITE_OP);
	assign bank_row   = first_line ? cur_row0[sel] : cur_row1[sel];
	assign bank_wdata = first_line ? cur_wdata0[sel] : cur_wdata1[sel];
	assign bank_bmask = first_line ? cur_bmask0[sel] : cur_bmask1[sel];

endmodule

/* hdl/mem_req_ctrl.sv */
// arbitration is external: gnt per bank must be at most one-hot and only to a raised bank_req
`timescale 1ns/1ps

module mem_req_ctrl (
	input  logic                                                        clk,
	input  logic                                                        rst_n,
	input  logic [mem_ctrl_pkg::NUM_CLIENTS-1:0]                        rd_req,
	input  logic [mem_ctrl_pkg::NUM_CLIENTS-1:0]                        wr_req,
	input  mem_geom_pkg::addr_t [mem_ctrl_pkg::NUM_CLIENTS-1:0]         start_addr,
	input  mem_ctrl_pkg::size_t [mem_ctrl_pkg::NUM_CLIENTS-1:0]         size,
	input  mem_geom_pkg::line_t [mem_ctrl_pkg::NUM_CLIENTS-1:0]         wr_data,
	output logic [mem_ctrl_pkg::NUM_CLIENTS-1:0]                        rd_valid,
	output mem_geom_pkg::line_t [mem_ctrl_pkg::NUM_CLIENTS-1:0]         rd_data,
	output logic [mem_ctrl_pkg::NUM_CLIENTS-1:0]                        wr_ack,
	output logic [mem_geom_pkg::NUM_BANKS-1:0][mem_ctrl_pkg::NUM_CLIENTS-1:0] bank_req,
	input  logic [mem_geom_pkg::NUM_BANKS-1:0][mem_ctrl_pkg::NUM_CLIENTS-1:0] gnt,
	output logic [mem_geom_pkg::NUM_BANKS-1:0]                          bank_cs,
	output logic [mem_geom_pkg::NUM_BANKS-1:0]                          bank_we,
	output mem_geom_pkg::row_t   [mem_geom_pkg::NUM_BANKS-1:0]          bank_row,
	output mem_geom_pkg::line_t  [mem_geom_pkg::NUM_BANKS-1:0]          bank_wdata,
	output mem_geom_pkg::bmask_t [mem_geom_pkg::NUM_BANKS-1:0]          bank_bmask,
	input  mem_geom_pkg::line_t  [mem_geom_pkg::NUM_BANKS-1:0]          bank_rdata
);
	import mem_geom_pkg::*;
	import mem_ctrl_pkg::*;

	// captured request of every client, fanned out to all banks
	op_e     [NUM_CLIENTS-1:0] cur_op;
	logic    [NUM_CLIENTS-1:0] cur_two;
	bank_t   [NUM_CLIENTS-1:0] cur_bank0;
	bank_t   [NUM_CLIENTS-1:0] cur_bank1;
	row_t    [NUM_CLIENTS-1:0] cur_row0;
	row_t    [NUM_CLIENTS-1:0] cur_row1;
	line_t   [NUM_CLIENTS-1:0] cur_wdata0;
	line_t   [NUM_CLIENTS-1:0] cur_wdata1;
	bmask_t  [NUM_CLIENTS-1:0] cur_bmask0;
	bmask_t  [NUM_CLIENTS-1:0] cur_bmask1;
	offset_t [NUM_CLIENTS-1:0] cur_offset;
	logic    [NUM_CLIENTS-1:0] line0_got;
	logic    [NUM_CLIENTS-1:0] line1_got;
	// client-major views of the bank-major request and grant matrices
	logic [NUM_CLIENTS-1:0][NUM_BANKS-1:0] req_row;
	logic [NUM_CLIENTS-1:0][NUM_BANKS-1:0] gnt_col;

	// ----------------------------------------
	// matrix transpose
	// ----------------------------------------

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_xpose
		for (genvar c = 0; c < NUM_CLIENTS; c++) begin : g_cl
			assign bank_req[b][c] = req_row[c][b];
			assign gnt_col[c][b]  = gnt[b][c];
		end
	end

	// ----------------------------------------
	// per-client sequencer and read path
	// ----------------------------------------

	for (genvar c = 0; c < NUM_CLIENTS; c++) begin : g_client
		access_seq access_seq_i (
			.clk          (clk),
			.rst_n        (rst_n),
			.rd_req       (rd_req[c]),
			.wr_req       (wr_req[c]),
			.start_addr   (start_addr[c]),
			.size         (size[c]),
			.wr_data      (wr_data[c]),
			.gnt_col      (gnt_col[c]),
			.cur_op       (cur_op[c]),
			.cur_two      (cur_two[c]),
			.cur_bank0    (cur_bank0[c]),
			.cur_bank1    (cur_bank1[c]),
			.cur_row0     (cur_row0[c]),
			.cur_row1     (cur_row1[c]),
			.cur_wdata0   (cur_wdata0[c]),
			.cur_wdata1   (cur_wdata1[c]),
			.cur_bmask0   (cur_bmask0[c]),
			.cur_bmask1   (cur_bmask1[c]),
			.cur_offset   (cur_offset[c]),
			.bank_req_row (req_row[c]),
			.line0_got    (line0_got[c]),
			.line1_got    (line1_got[c]),
			.rd_valid     (rd_valid[c]),
			.wr_ack       (wr_ack[c])
		);

		read_merge read_merge_i (
			.clk        (clk),
			.rst_n      (rst_n),
			.bank_rdata (bank_rdata),
			.cur_bank0  (cur_bank0[c]),
			.cur_bank1  (cur_bank1[c]),
			.cur_two    (cur_two[c]),
			.cur_offset (cur_offset[c]),
			.line0_got  (line0_got[c]),
			.line1_got  (line1_got[c]),
			.rd_data    (rd_data[c])
		);
	end

	// ----------------------------------------
	// per-bank port drive
	// ----------------------------------------

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		bank_port_mux #(
			.bank_idx (b)
		) bank_port_mux_i (
			.gnt_row    (gnt[b]),
			.cur_op     (cur_op),
			.cur_bank0  (cur_bank0),
			.cur_row0   (cur_row0),
			.cur_row1   (cur_row1),
			.cur_wdata0 (cur_wdata0),
			.cur_wdata1 (cur_wdata1),
			.cur_bmask0 (cur_bmask0),
			.cur_bmask1 (cur_bmask1),
			.bank_cs    (bank_cs[b]),
			.bank_we    (bank_we[b]),
			.bank_row   (bank_row[b]),
			.bank_wdata (bank_wdata[b]),
			.bank_bmask (bank_bmask[b])
		);
	end

endmodule

/* verif/mem_req_checker.sv */
// protocol checks only; assumes gnt comes from an arbiter that grants raised bank_req lines
`timescale 1ns/1ps

module mem_req_checker (
	input logic                                                         clk,
	input logic                                                         rst_n,
	input logic [mem_ctrl_pkg::NUM_CLIENTS-1:0]                         rd_valid,
	input logic [mem_ctrl_pkg::NUM_CLIENTS-1:0]                         wr_ack,
	input logic [mem_geom_pkg::NUM_BANKS-1:0][mem_ctrl_pkg::NUM_CLIENTS-1:0] bank_req,
	input logic [mem_geom_pkg::NUM_BANKS-1:0][mem_ctrl_pkg::NUM_CLIENTS-1:0] gnt,
	input logic [mem_geom_pkg::NUM_BANKS-1:0]                           bank_cs
);
	import mem_geom_pkg::*;
	import mem_ctrl_pkg::*;

	// banks requested by each client
	logic [NUM_CLIENTS-1:0][NUM_BANKS-1:0] req_by_client;

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_xpose
		for (genvar c = 0; c < NUM_CLIENTS; c++) begin : g_cl
			assign req_by_client[c][b] = bank_req[b][c];
		end
	end

	// ----------------------------------------
	// client side
	// ----------------------------------------

	for (genvar c = 0; c < NUM_CLIENTS; c++) begin : g_count
		// either pulse alone, and for one cycle only
		no_valid_with_ack: assert property (@(posedge clk) disable iff (!rst_n)
			rd_valid[c] || wr_ack[c] |=>
				!$past(rd_valid[c] && wr_ack[c]) && !rd_valid[c] && !wr_ack[c])
			else $error("client %0d rd_valid and wr_ack together or held too long", c);
		// a request spans one or two lines, no bank joins while some are open
		two_banks_max: assert property (@(posedge clk) disable iff (!rst_n)
			$countones(req_by_client[c]) <= 2
				&& ($past(req_by_client[c]) == '0
				|| (req_by_client[c] & ~$past(req_by_client[c])) == '0))
			else $error("client %0d requests more than two banks or adds one", c);
	end

	// ----------------------------------------
	// bank side
	// ----------------------------------------

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		// select only where a grant meets a raised request
		cs_follows_gnt: assert property (@(posedge clk) disable iff (!rst_n)
			bank_cs[b] == |(gnt[b] & bank_req[b]))
			else $error("bank_cs of bank %0d does not follow a granted request", b);
		for (genvar c = 0; c < NUM_CLIENTS; c++) begin : g_client
			req_held: assert property (@(posedge clk) disable iff (!rst_n)
				bank_req[b][c] && !gnt[b][c] |=> bank_req[b][c])
				else $error("bank_req of bank %0d client %0d dropped before grant", b, c);
		end
	end

endmodule

/* verif/mem_req_tb.sv */
// clients keep to disjoint rows so the byte reference stays exact; sizes are 1..32 bytes
`timescale 1ns/1ps

module mem_req_tb;
	import mem_geom_pkg::*;
	import mem_ctrl_pkg::*;

	localparam int REQ_COUNT = 300;
	localparam int PERIOD = 8;
	localparam logic [31:0] SEED = 32'hc923c4af;
	// client model phases
	localparam int PH_IDLE = 0;
	localparam int PH_SENT = 1;
	localparam int PH_WAIT = 2;
	localparam int PH_DONE = 3;

	logic                                  clk;
	logic                                  rst_n;
	logic [NUM_CLIENTS-1:0]                rd_req;
	logic [NUM_CLIENTS-1:0]                wr_req;
	addr_t [NUM_CLIENTS-1:0]               start_addr;
	size_t [NUM_CLIENTS-1:0]               size;
	line_t [NUM_CLIENTS-1:0]               wr_data;
	logic [NUM_CLIENTS-1:0]                rd_valid;
	line_t [NUM_CLIENTS-1:0]               rd_data;
	logic [NUM_CLIENTS-1:0]                wr_ack;
	logic [NUM_BANKS-1:0][NUM_CLIENTS-1:0] bank_req;
	logic [NUM_BANKS-1:0][NUM_CLIENTS-1:0] gnt;
	logic [NUM_BANKS-1:0]                  bank_cs;
	logic [NUM_BANKS-1:0]                  bank_we;
	row_t [NUM_BANKS-1:0]                  bank_row;
	line_t [NUM_BANKS-1:0]                 bank_wdata;
	bmask_t [NUM_BANKS-1:0]                bank_bmask;
	line_t [NUM_BANKS-1:0]                 bank_rdata;

	// client model, one request each
	int         phase [NUM_CLIENTS];
	int         issued [NUM_CLIENTS];
	int         finished;
	logic       is_wr [NUM_CLIENTS];
	addr_t      req_addr [NUM_CLIENTS];
	int         req_size [NUM_CLIENTS];
	line_t      req_data [NUM_CLIENTS];
	logic       pend0 [NUM_CLIENTS];
	logic       pend1 [NUM_CLIENTS];
	// bank lines keyed by bank*1024+row, reference bytes keyed by address
	line_t      bank_mem [int];
	logic [7:0] ref_mem [int];
	logic [31:0] lfsr;
	int         checks;
	int         mismatches;

	mem_req_ctrl mem_req_ctrl_i (.*);

	bind mem_req_ctrl mem_req_checker mem_req_checker_i (.*);

	always #(PERIOD / 2) clk = ~clk;

	// ----------------------------------------
	// helpers
	// ----------------------------------------

	// taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step for every bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [7:0] fill_byte(input addr_t a);
		return (a[7:0] + 8'h5a) ^ a[15:8] ^ {a[18:16], 5'b10011};
	endfunction

	// region in 18..16, odd/even line in bit 5
	function automatic bank_t bank_of(input addr_t a);
		return {a[18:16], a[5]};
	endfunction

	function automatic addr_t next_line(input addr_t a);
		return a + addr_t'(LINE_BYTES);
	endfunction

	function automatic addr_t byte_addr(input int b, input row_t r, input int j);
		bank_t bk;
		bk = bank_t'(b);
		return {bk[3:1], r, bk[0], offset_t'(j)};
	endfunction

	function automatic line_t line_at(input int b, input row_t r);
		line_t l;
		if (bank_mem.exists(b * 1024 + int'(r))) begin
			return bank_mem[b * 1024 + int'(r)];
		end
		for (int j = 0; j < LINE_BYTES; j++) begin
			l[j*8 +: 8] = fill_byte(byte_addr(b, r, j));
		end
		return l;
	endfunction

	function automatic logic [7:0] ref_byte(input addr_t a);
		if (ref_mem.exists(int'(a))) begin
			return ref_mem[int'(a)];
		end
		return fill_byte(a);
	endfunction

	function automatic logic spans_two(input int c);
		return int'(req_addr[c][OFFSET_W-1:0]) + req_size[c] > LINE_BYTES;
	endfunction

	// open bank request of a client for the coming cycle
	function automatic logic wants_bank(input int c, input int b);
		return phase[c] == PH_WAIT
			&& ((pend0[c] && bank_of(req_addr[c]) == bank_t'(b))
			|| (pend1[c] && bank_of(next_line(req_addr[c])) == bank_t'(b)));
	endfunction

	task automatic expect_eq(input string what, input logic [255:0] got,
		input logic [255:0] exp);
		checks++;
		assert (got === exp) else begin
			mismatches++;
			$display("MISMATCH %s got=%0h exp=%0h", what, got, exp);
		end
	endtask

	// ----------------------------------------
	// client stimulus
	// ----------------------------------------

	task automatic start_request(input int c);
		logic [2:0] region;
		row_t row;
		logic b5;
		offset_t off;
		region = 3'(rand_bits(3));
		case (2'(rand_bits(2)))
			2'd0: row = row_t'(4 * c + 1);
			2'd1, 2'd2: row = row_t'(4 * c + 2);
			default: begin
				// last row, crossing into the next region
				row = '1;
				region = 3'(2 * c);
			end
		endcase
		b5 = 1'(rand_bits(1));
		off = offset_t'(rand_bits(5));
		is_wr[c] = 1'(rand_bits(1));
		req_addr[c] = {region, row, b5, off};
		req_size[c] = int'(rand_bits(5)) + 1;
		for (int i = 0; i < 8; i++) begin
			req_data[c][i*32 +: 32] = rand_bits(32);
		end
		rd_req[c] <= !is_wr[c];
		wr_req[c] <= is_wr[c];
		start_addr[c] <= req_addr[c];
		size[c] <= size_t'(req_size[c]);
		wr_data[c] <= req_data[c];
		issued[c]++;
		phase[c] = PH_SENT;
	endtask

	task automatic finish_request(input int c);
		addr_t a;
		for (int i = 0; i < req_size[c]; i++) begin
			a = req_addr[c] + addr_t'(i);
			if (is_wr[c]) begin
				ref_mem[int'(a)] = req_data[c][i*8 +: 8];
			end else begin
				expect_eq($sformatf("rd_data[%0d] byte %0d", c, i),
					rd_data[c][i*8 +: 8], ref_byte(a));
			end
		end
		rd_req[c] <= 1'b0;
		wr_req[c] <= 1'b0;
		finished++;
	endtask

	task automatic step_client(input int c);
		logic [NUM_BANKS-1:0] col;
		logic [NUM_BANKS-1:0] exp_col;
		logic done;
		for (int b = 0; b < NUM_BANKS; b++) begin
			col[b] = bank_req[b][c];
			exp_col[b] = wants_bank(c, b);
		end
		done = phase[c] == PH_DONE;
		expect_eq($sformatf("bank_req[*][%0d]", c), col, exp_col);
		expect_eq($sformatf("rd_valid[%0d]", c), rd_valid[c], done && !is_wr[c]);
		expect_eq($sformatf("wr_ack[%0d]", c), wr_ack[c], done && is_wr[c]);
		case (phase[c])
			PH_SENT: begin
				// captured at this edge, bank requests rise next cycle
				pend0[c] = 1'b1;
				pend1[c] = spans_two(c);
				phase[c] = PH_WAIT;
			end
			PH_WAIT: begin
				if (pend0[c] && gnt[bank_of(req_addr[c])][c]) begin
					pend0[c] = 1'b0;
				end
				if (pend1[c] && gnt[bank_of(next_line(req_addr[c]))][c]) begin
					pend1[c] = 1'b0;
				end
				// valid or ack due in the cycle after the last grant
				if (!pend0[c] && !pend1[c]) begin
					phase[c] = PH_DONE;
				end
			end
			PH_DONE: begin
				finish_request(c);
				phase[c] = PH_IDLE;
			end
			default: begin
			end
		endcase
		if (phase[c] == PH_IDLE && issued[c] < REQ_COUNT && rand_bits(2) != 0) begin
			start_request(c);
		end
	endtask

	// ----------------------------------------
	// bank model and arbiter
	// ----------------------------------------

	task automatic check_granted_port(input int b);
		int c;
		addr_t a;
		addr_t d;
		bmask_t exp_mask;
		c = 0;
		for (int k = 0; k < NUM_CLIENTS; k++) begin
			if (gnt[b][k]) begin
				c = k;
			end
		end
		a = (bank_of(req_addr[c]) == bank_t'(b)) ? req_addr[c] : next_line(req_addr[c]);
		expect_eq($sformatf("bank_we[%0d]", b), bank_we[b], is_wr[c]);
		expect_eq($sformatf("bank_row[%0d]", b), bank_row[b], a[15:6]);
		if (is_wr[c]) begin
			for (int j = 0; j < LINE_BYTES; j++) begin
				d = byte_addr(b, a[15:6], j) - req_addr[c];
				exp_mask[j] = int'(d) < req_size[c];
				if (exp_mask[j]) begin
					expect_eq($sformatf("bank_wdata[%0d] byte %0d", b, j),
						bank_wdata[b][j*8 +: 8], req_data[c][int'(d)*8 +: 8]);
				end
			end
			expect_eq($sformatf("bank_bmask[%0d]", b), bank_bmask[b], exp_mask);
		end
	endtask

	task automatic serve_banks();
		line_t cur;
		for (int b = 0; b < NUM_BANKS; b++) begin
			// the bank is selected in the grant cycle only
			expect_eq($sformatf("bank_cs[%0d]", b), bank_cs[b], gnt[b] != '0);
			if (gnt[b] != '0) begin
				check_granted_port(b);
			end
			if (bank_cs[b]) begin
				cur = line_at(b, bank_row[b]);
				if (bank_we[b]) begin
					for (int j = 0; j < LINE_BYTES; j++) begin
						if (bank_bmask[b][j]) begin
							cur[j*8 +: 8] = bank_wdata[b][j*8 +: 8];
						end
					end
					bank_mem[b * 1024 + int'(bank_row[b])] = cur;
				end else begin
					// read data in the cycle after the grant
					bank_rdata[b] <= cur;
				end
			end
		end
	endtask

	task automatic drive_grants();
		logic [NUM_CLIENTS-1:0] cand;
		logic [NUM_CLIENTS-1:0] pick_vec;
		int pick;
		for (int b = 0; b < NUM_BANKS; b++) begin
			pick_vec = '0;
			for (int c = 0; c < NUM_CLIENTS; c++) begin
				cand[c] = wants_bank(c, b);
			end
			// a busy bank withholds its grant half the time
			if (cand != '0 && rand_bits(1) == 1) begin
				pick = int'(rand_bits(2));
				while (!cand[pick]) begin
					pick = (pick + 1) % NUM_CLIENTS;
				end
				pick_vec[pick] = 1'b1;
			end
			gnt[b] <= pick_vec;
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			expect_eq("rd_valid in reset", rd_valid, '0);
			expect_eq("wr_ack in reset", wr_ack, '0);
			expect_eq("bank_req in reset", bank_req, '0);
			expect_eq("bank_cs in reset", bank_cs, '0);
		end else begin
			serve_banks();
			for (int c = 0; c < NUM_CLIENTS; c++) begin
				step_client(c);
			end
			drive_grants();
		end
	end

	// ----------------------------------------
	// run control
	// ----------------------------------------

	initial begin
		clk = 1'b0;
		rst_n = 1'b1;
		rd_req = '0;
		wr_req = '0;
		start_addr = '0;
		size = {NUM_CLIENTS{6'd1}};
		wr_data = '0;
		gnt = '0;
		bank_rdata = '0;
		lfsr = SEED;
		finished = 0;
		checks = 0;
		mismatches = 0;
		for (int c = 0; c < NUM_CLIENTS; c++) begin
			phase[c] = PH_IDLE;
			issued[c] = 0;
			is_wr[c] = 1'b0;
			req_addr[c] = '0;
			req_size[c] = 1;
			req_data[c] = '0;
			pend0[c] = 1'b0;
			pend1[c] = 1'b0;
		end
		#(PERIOD / 4);
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		while (finished < NUM_CLIENTS * REQ_COUNT) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		$display("checks %0d, mismatches %0d", checks, mismatches);
		if (mismatches == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// generous bound of 40 cycles per request
	initial begin
		#(REQ_COUNT * 40 * PERIOD);
		$display("timeout, only %0d of %0d requests completed", finished,
			NUM_CLIENTS * REQ_COUNT);
		$display("checks %0d, mismatches %0d", checks, mismatches);
		$display("Regression failed");
		$finish;
	end

endmodule

/* list.f */
hdl/mem_geom_pkg.sv
hdl/mem_ctrl_pkg.sv
hdl/line_split.sv
hdl/access_seq.sv
hdl/read_merge.sv
hdl/bank_port_mux.sv
hdl/mem_req_ctrl.sv
verif/mem_req_checker.sv
verif/mem_req_tb.sv
